//--- include/miriscv_params.svh
`ifndef MIRISCV_PARAMS_SVH
`define MIRISCV_PARAMS_SVH

// **************************************************
// Core dimensions
// **************************************************

`define XLEN          32       // Width of a machine word.
`define REG_COUNT     32       // Number of general purpose registers.
`define RESET_VECTOR  32'h0    // First fetch address after reset.

// **************************************************
// Raw immediate field widths
// **************************************************

// These are the widths before sign or zero extension to XLEN.
`define IMM_I_W       12
`define IMM_S_W       12
`define IMM_B_W       13       // Includes the implicit zero LSB.
`define IMM_J_W       21       // Includes the implicit zero LSB.
`define IMM_U_W       20

`endif

//--- src/miriscv_pkg.sv
`include "miriscv_params.svh"

package miriscv_pkg;

  // **************************************************
  // Encodings
  // **************************************************

  // Major opcodes of the RV32I subset this core executes.
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // Compare operations sit in the upper half so bit 4 marks a branch compare.
  typedef enum logic [4:0] {
    ALU_ADD  = 5'b00000,
    ALU_SLL  = 5'b00001,
    ALU_SLT  = 5'b00010,
    ALU_SLTU = 5'b00011,
    ALU_XOR  = 5'b00100,
    ALU_SRL  = 5'b00101,
    ALU_OR   = 5'b00110,
    ALU_AND  = 5'b00111,
    ALU_SUB  = 5'b01000,
    ALU_SRA  = 5'b01101,
    ALU_EQ   = 5'b11000,
    ALU_NE   = 5'b11001,
    ALU_LT   = 5'b11100,
    ALU_GE   = 5'b11101,
    ALU_LTU  = 5'b11110,
    ALU_GEU  = 5'b11111
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_RS1     = 2'd0,
    OP_A_CURR_PC = 2'd1,
    OP_A_ZERO    = 2'd2
  } op_a_sel_e;

  typedef enum logic [2:0] {
    OP_B_RS2   = 3'd0,
    OP_B_IMM_I = 3'd1,
    OP_B_IMM_U = 3'd2,
    OP_B_IMM_S = 3'd3,
    OP_B_INCR  = 3'd4
  } op_b_sel_e;

  // Values follow funct3 of the load and store instructions.
  typedef enum logic [2:0] {
    MEM_BYTE   = 3'd0,
    MEM_HALF   = 3'd1,
    MEM_WORD   = 3'd2,
    MEM_BYTE_U = 3'd4,
    MEM_HALF_U = 3'd5
  } mem_size_e;

  // **************************************************
  // Control bundles
  // **************************************************

  typedef struct packed {
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    alu_op_e   alu_op;
    logic      mem_req;
    logic      mem_we;
    mem_size_e mem_size;
    logic      gpr_we;
    logic      wb_from_mem;  // Write back the LSU data instead of the ALU result.
    logic      branch;
    logic      jal;
    logic      jalr;
    logic      illegal;
  } ctrl_t;

  typedef struct packed {
    logic             req;
    logic             we;
    mem_size_e        size;
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] wdata;
  } lsu_req_t;

endpackage

//--- src/miriscv_alu.sv
`timescale 1ns/1ns
`include "miriscv_params.svh"

module miriscv_alu (
  input  miriscv_pkg::alu_op_e op_i,
  input  logic [`XLEN-1:0]     a_i,
  input  logic [`XLEN-1:0]     b_i,
  output logic [`XLEN-1:0]     result_o,
  output logic                 flag_o
);
  import miriscv_pkg::*;

  logic [4:0] shamt;

  assign shamt = b_i[4:0];  // Shifts look at the low five bits only.

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SLT:  result_o = {{(`XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
      ALU_SLTU: result_o = {{(`XLEN-1){1'b0}}, a_i < b_i};
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
      ALU_OR:   result_o = a_i | b_i;
      ALU_AND:  result_o = a_i & b_i;
      default:  result_o = '0;  // Compare operations produce only the flag.
    endcase
  end

  // Branch condition.
  always_comb begin
    case (op_i)
      ALU_EQ:  flag_o = (a_i == b_i);
      ALU_NE:  flag_o = (a_i != b_i);
      ALU_LT:  flag_o = ($signed(a_i) < $signed(b_i));
      ALU_GE:  flag_o = ($signed(a_i) >= $signed(b_i));
      ALU_LTU: flag_o = (a_i < b_i);
      ALU_GEU: flag_o = (a_i >= b_i);
      default: flag_o = 1'b0;
    endcase
  end

endmodule

//--- src/miriscv_decoder.sv
`timescale 1ns/1ns
`include "miriscv_params.svh"

module miriscv_decoder (
  input  logic [`XLEN-1:0]   instr_i,
  input  logic               lsu_stall_i,
  output miriscv_pkg::ctrl_t ctrl_o,
  output logic [`XLEN-1:0]   imm_o,
  output logic               pc_en_o
);
  import miriscv_pkg::*;

  opcode_e              opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic [`IMM_I_W-1:0]  imm_i;
  logic [`IMM_S_W-1:0]  imm_s;
  logic [`IMM_B_W-1:0]  imm_b;
  logic [`IMM_J_W-1:0]  imm_j;
  logic [`IMM_U_W-1:0]  imm_u;
  ctrl_t                dec;  // Decoded controls before the stall gate.

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // **************************************************
  // Immediates
  // **************************************************

  assign imm_i = instr_i[31:20];
  assign imm_s = {instr_i[31:25], instr_i[11:7]};
  assign imm_b = {instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_j = {instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
  assign imm_u = instr_i[31:12];

  always_comb begin
    case (opcode)
      OPC_STORE:          imm_o = {{(`XLEN-`IMM_S_W){imm_s[`IMM_S_W-1]}}, imm_s};
      OPC_BRANCH:         imm_o = {{(`XLEN-`IMM_B_W){imm_b[`IMM_B_W-1]}}, imm_b};
      OPC_JAL:            imm_o = {{(`XLEN-`IMM_J_W){imm_j[`IMM_J_W-1]}}, imm_j};
      OPC_LUI, OPC_AUIPC: imm_o = {imm_u, {(`XLEN-`IMM_U_W){1'b0}}};
      default:            imm_o = {{(`XLEN-`IMM_I_W){imm_i[`IMM_I_W-1]}}, imm_i};
    endcase
  end

  // **************************************************
  // Control decode
  // **************************************************

  always_comb begin
    dec          = '0;
    dec.op_a_sel = OP_A_RS1;
    dec.op_b_sel = OP_B_RS2;
    dec.alu_op   = ALU_ADD;  // Address and link arithmetic all use ADD.
    dec.mem_size = MEM_WORD;

    case (opcode)
      OPC_LUI: begin
        dec.op_a_sel = OP_A_ZERO;
        dec.op_b_sel = OP_B_IMM_U;
        dec.gpr_we   = 1'b1;
      end
      OPC_AUIPC: begin
        dec.op_a_sel = OP_A_CURR_PC;
        dec.op_b_sel = OP_B_IMM_U;
        dec.gpr_we   = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        // The ALU forms the link value PC + 4; the target is built in the core.
        dec.op_a_sel = OP_A_CURR_PC;
        dec.op_b_sel = OP_B_INCR;
        dec.gpr_we   = 1'b1;
        dec.jal      = (opcode == OPC_JAL);
        dec.jalr     = (opcode == OPC_JALR);
        dec.illegal  = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        dec.branch = 1'b1;
        case (funct3)
          3'b000:  dec.alu_op = ALU_EQ;
          3'b001:  dec.alu_op = ALU_NE;
          3'b100:  dec.alu_op = ALU_LT;
          3'b101:  dec.alu_op = ALU_GE;
          3'b110:  dec.alu_op = ALU_LTU;
          3'b111:  dec.alu_op = ALU_GEU;
          default: dec.illegal = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        dec.op_b_sel    = OP_B_IMM_I;
        dec.mem_req     = 1'b1;
        dec.gpr_we      = 1'b1;
        dec.wb_from_mem = 1'b1;
        dec.mem_size    = mem_size_e'(funct3);
        dec.illegal     = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      OPC_STORE: begin
        dec.op_b_sel = OP_B_IMM_S;
        dec.mem_req  = 1'b1;
        dec.mem_we   = 1'b1;
        dec.mem_size = mem_size_e'(funct3);
        dec.illegal  = funct3[2] || (funct3[1:0] == 2'b11);
      end
      OPC_OP_IMM: begin
        dec.op_b_sel = OP_B_IMM_I;
        dec.gpr_we   = 1'b1;
        case (funct3)
          3'b000: dec.alu_op = ALU_ADD;
          3'b010: dec.alu_op = ALU_SLT;
          3'b011: dec.alu_op = ALU_SLTU;
          3'b100: dec.alu_op = ALU_XOR;
          3'b110: dec.alu_op = ALU_OR;
          3'b111: dec.alu_op = ALU_AND;
          3'b001: begin
            dec.alu_op  = ALU_SLL;
            dec.illegal = (funct7 != 7'h00);
          end
          default: begin  // funct3 101 holds both right shifts.
            dec.alu_op  = (funct7 == 7'h20) ? ALU_SRA : ALU_SRL;
            dec.illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
        endcase
      end
      OPC_OP: begin
        dec.gpr_we = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: dec.alu_op = ALU_ADD;
          {7'h20, 3'b000}: dec.alu_op = ALU_SUB;
          {7'h00, 3'b001}: dec.alu_op = ALU_SLL;
          {7'h00, 3'b010}: dec.alu_op = ALU_SLT;
          {7'h00, 3'b011}: dec.alu_op = ALU_SLTU;
          {7'h00, 3'b100}: dec.alu_op = ALU_XOR;
          {7'h00, 3'b101}: dec.alu_op = ALU_SRL;
          {7'h20, 3'b101}: dec.alu_op = ALU_SRA;
          {7'h00, 3'b110}: dec.alu_op = ALU_OR;
          {7'h00, 3'b111}: dec.alu_op = ALU_AND;
          default:         dec.illegal = 1'b1;
        endcase
      end
      default: dec.illegal = 1'b1;
    endcase

    // An illegal word retires as a no-op with no side effects.
    if (dec.illegal) begin
      dec.gpr_we  = 1'b0;
      dec.mem_req = 1'b0;
      dec.mem_we  = 1'b0;
      dec.branch  = 1'b0;
      dec.jal     = 1'b0;
      dec.jalr    = 1'b0;
    end
  end

  always_comb begin
    ctrl_o        = dec;
    ctrl_o.gpr_we = dec.gpr_we & ~lsu_stall_i;  // Write only in the data phase.
  end

  assign pc_en_o = ~lsu_stall_i;

endmodule

//--- src/miriscv_regfile.sv
`timescale 1ns/1ns
`include "miriscv_params.svh"

module miriscv_regfile (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic [4:0]       ra1_i,
  input  logic [4:0]       ra2_i,
  input  logic [4:0]       wa_i,
  input  logic [`XLEN-1:0] wd_i,
  input  logic             we_i,
  output logic [`XLEN-1:0] rd1_o,
  output logic [`XLEN-1:0] rd2_o
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  // Register x0 is cleared by reset and never written, so it reads as zero.
  always_ff @(posedge clk_i or posedge rst_n_i) begin
    if (rst_n_i) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (wa_i != 5'd0)) begin
      regs[wa_i] <= wd_i;
    end
  end

  assign rd1_o = regs[ra1_i];  // Asynchronous read ports.
  assign rd2_o = regs[ra2_i];

endmodule

//--- src/miriscv_lsu.sv
`timescale 1ns/1ns
`include "miriscv_params.svh"

module miriscv_lsu (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  miriscv_pkg::lsu_req_t req_i,
  output logic                  stall_o,
  output logic [`XLEN-1:0]      rdata_o,
  input  logic [`XLEN-1:0]      data_rdata_i,
  output logic                  data_req_o,
  output logic                  data_we_o,
  output logic [3:0]            data_be_o,
  output logic [`XLEN-1:0]      data_addr_o,
  output logic [`XLEN-1:0]      data_wdata_o
);
  import miriscv_pkg::*;

  logic        data_phase;  // High in the second cycle of an access.
  logic [1:0]  offset;
  logic [7:0]  rd_byte;
  logic [15:0] rd_half;

  assign offset = req_i.addr[1:0];

  // **************************************************
  // Request phase
  // **************************************************

  always_ff @(posedge clk_i or posedge rst_n_i) begin
    if (rst_n_i) begin
      data_phase <= 1'b0;
    end else begin
      data_phase <= stall_o;
    end
  end

  assign stall_o     = req_i.req & ~data_phase;
  assign data_req_o  = stall_o;     // One strobe per access.
  assign data_we_o   = req_i.we;
  assign data_addr_o = req_i.addr;

  always_comb begin
    case (req_i.size)
      MEM_BYTE, MEM_BYTE_U: data_be_o = 4'b0001 << offset;
      MEM_HALF, MEM_HALF_U: data_be_o = offset[1] ? 4'b1100 : 4'b0011;
      default:              data_be_o = 4'b1111;
    endcase
  end

  // The memory picks its lanes through data_be_o.
  always_comb begin
    case (req_i.size)
      MEM_BYTE, MEM_BYTE_U: data_wdata_o = {4{req_i.wdata[7:0]}};
      MEM_HALF, MEM_HALF_U: data_wdata_o = {2{req_i.wdata[15:0]}};
      default:              data_wdata_o = req_i.wdata;
    endcase
  end

  // **************************************************
  // Data phase
  // **************************************************

  assign rd_byte = data_rdata_i[{offset, 3'b000} +: 8];
  assign rd_half = offset[1] ? data_rdata_i[31:16] : data_rdata_i[15:0];

  always_comb begin
    case (req_i.size)
      MEM_BYTE:   rdata_o = {{(`XLEN-8){rd_byte[7]}}, rd_byte};
      MEM_BYTE_U: rdata_o = {{(`XLEN-8){1'b0}}, rd_byte};
      MEM_HALF:   rdata_o = {{(`XLEN-16){rd_half[15]}}, rd_half};
      MEM_HALF_U: rdata_o = {{(`XLEN-16){1'b0}}, rd_half};
      default:    rdata_o = data_rdata_i;
    endcase
  end

endmodule

//--- src/miriscv_core.sv
`timescale 1ns/1ns
`include "miriscv_params.svh"

module miriscv_core (
  input  logic             clk_i,
  input  logic             rst_n_i,

  input  logic [`XLEN-1:0] instr_rdata_i,
  output logic [`XLEN-1:0] instr_addr_o,

  input  logic [`XLEN-1:0] data_rdata_i,
  output logic             data_req_o,
  output logic             data_we_o,
  output logic [3:0]       data_be_o,
  output logic [`XLEN-1:0] data_addr_o,
  output logic [`XLEN-1:0] data_wdata_o
);
  import miriscv_pkg::*;

  ctrl_t            ctrl;
  lsu_req_t         lsu_req;
  logic [`XLEN-1:0] imm;
  logic             pc_en;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] pc_next;
  logic [`XLEN-1:0] rd1;
  logic [`XLEN-1:0] rd2;
  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_result;
  logic             alu_flag;
  logic             lsu_stall;
  logic [`XLEN-1:0] lsu_rdata;
  logic [`XLEN-1:0] wb_data;

  assign instr_addr_o = pc;

  miriscv_decoder u_decoder (
    .instr_i     (instr_rdata_i),
    .lsu_stall_i (lsu_stall),
    .ctrl_o      (ctrl),
    .imm_o       (imm),
    .pc_en_o     (pc_en)
  );

  miriscv_regfile u_regfile (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .ra1_i   (instr_rdata_i[19:15]),
    .ra2_i   (instr_rdata_i[24:20]),
    .wa_i    (instr_rdata_i[11:7]),
    .wd_i    (wb_data),
    .we_i    (ctrl.gpr_we),
    .rd1_o   (rd1),
    .rd2_o   (rd2)
  );

  // **************************************************
  // Execute
  // **************************************************

  always_comb begin
    case (ctrl.op_a_sel)
      OP_A_RS1:     op_a = rd1;
      OP_A_CURR_PC: op_a = pc;
      default:      op_a = '0;
    endcase
  end

  // The decoder has already picked the immediate format.
  always_comb begin
    case (ctrl.op_b_sel)
      OP_B_RS2:                           op_b = rd2;
      OP_B_IMM_I, OP_B_IMM_U, OP_B_IMM_S: op_b = imm;
      OP_B_INCR:                          op_b = `XLEN'd4;
      default:                            op_b = '0;
    endcase
  end

  miriscv_alu u_alu (
    .op_i     (ctrl.alu_op),
    .a_i      (op_a),
    .b_i      (op_b),
    .result_o (alu_result),
    .flag_o   (alu_flag)
  );

  always_comb begin
    lsu_req.req   = ctrl.mem_req;
    lsu_req.we    = ctrl.mem_we;
    lsu_req.size  = ctrl.mem_size;
    lsu_req.addr  = alu_result;  // Effective address is rs1 + offset.
    lsu_req.wdata = rd2;
  end

  miriscv_lsu u_lsu (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (lsu_req),
    .stall_o      (lsu_stall),
    .rdata_o      (lsu_rdata),
    .data_rdata_i (data_rdata_i),
    .data_req_o   (data_req_o),
    .data_we_o    (data_we_o),
    .data_be_o    (data_be_o),
    .data_addr_o  (data_addr_o),
    .data_wdata_o (data_wdata_o)
  );

  assign wb_data = ctrl.wb_from_mem ? lsu_rdata : alu_result;

  // **************************************************
  // Program counter
  // **************************************************

  always_comb begin
    if (ctrl.jalr) begin
      pc_next = (rd1 + imm) & ~`XLEN'd1;
    end else if (ctrl.jal || (ctrl.branch && alu_flag)) begin
      pc_next = pc + imm;
    end else begin
      pc_next = pc + `XLEN'd4;
    end
  end

  always_ff @(posedge clk_i or posedge rst_n_i) begin
    if (rst_n_i) begin
      pc <= `RESET_VECTOR;
    end else if (pc_en) begin
      pc <= pc_next;  // Held through the first cycle of a memory access.
    end
  end

endmodule

//--- test/miriscv_core_assert.sv
`timescale 1ns/1ns
`include "miriscv_params.svh"

module miriscv_core_assert (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic [`XLEN-1:0]      instr_addr_o,
  input logic                  data_req_o,
  input logic [3:0]            data_be_o,
  input logic                  lsu_stall,
  input logic                  alu_flag,
  input miriscv_pkg::ctrl_t    ctrl,
  input miriscv_pkg::lsu_req_t lsu_req
);
  import miriscv_pkg::*;

  int fail_count = 0;  // Number of failed assertions.

  // An access covers as many lanes as it has bytes, starting at the address offset.
  function automatic logic [3:0] be_rule(input mem_size_e size, input logic [1:0] off);
    logic [7:0] lanes;
    case (size)
      MEM_BYTE, MEM_BYTE_U: lanes = 8'h01;
      MEM_HALF, MEM_HALF_U: lanes = 8'h03;
      default:              lanes = 8'h0f;
    endcase
    lanes   = lanes << off;
    be_rule = lanes[3:0];
  endfunction

  a_reset: assert property (@(posedge clk_i) rst_n_i && $past(rst_n_i) |->
      (instr_addr_o == `RESET_VECTOR) && !data_req_o)
    else begin fail_count++; $error("PC or data request wrong during reset"); end

  a_single_strobe: assert property (@(posedge clk_i) disable iff (rst_n_i)
      data_req_o |=> !data_req_o)
    else begin fail_count++; $error("data request held for two cycles"); end

  a_stall_hold: assert property (@(posedge clk_i) disable iff (rst_n_i)
      lsu_stall |=> $stable(instr_addr_o))
    else begin fail_count++; $error("PC moved during an LSU stall"); end

  a_byte_enable: assert property (@(posedge clk_i) disable iff (rst_n_i)
      data_req_o |-> data_be_o == be_rule(lsu_req.size, lsu_req.addr[1:0]))
    else begin fail_count++; $error("byte enables disagree with size and address"); end

  a_pc_step: assert property (@(posedge clk_i) disable iff (rst_n_i)
      !lsu_stall && !ctrl.jal && !ctrl.jalr && !(ctrl.branch && alu_flag) |=>
      instr_addr_o == $past(instr_addr_o) + `XLEN'd4)
    else begin fail_count++; $error("PC did not advance by 4"); end

endmodule

bind miriscv_core miriscv_core_assert u_assert (.*);

//--- test/miriscv_core_tb.sv
`timescale 1ns/1ns
`include "miriscv_params.svh"

module miriscv_core_tb;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  be;
  } store_t;

  logic        clk_i;
  logic        rst_n_i;
  logic [31:0] instr_rdata_i;
  logic [31:0] instr_addr_o;
  logic [31:0] data_rdata_i;
  logic        data_req_o;
  logic        data_we_o;
  logic [3:0]  data_be_o;
  logic [31:0] data_addr_o;
  logic [31:0] data_wdata_o;

  logic [31:0] rom [0:255];
  logic [31:0] ram [0:1023];
  store_t      exp_q[$];
  store_t      cur_store;
  logic [31:0] lfsr = 32'hb24;
  logic [31:0] va, vb, imm;
  int          pw, out_off, end_pc;
  int          cycles = 0;
  int          limit = 10000;
  int          mismatches = 0;
  int          other_errors = 0;

  miriscv_core uut (.*);

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  assign instr_rdata_i = rom[instr_addr_o[9:2]];  // Combinational instruction port.

  // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once for every bit taken.
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // ************************************************
  // Instruction encoders
  // ************************************************

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] im, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {im, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] im, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {im[11:5], rs2, rs1, f3, im[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] im, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {im[12], im[10:5], rs2, rs1, f3, im[4:1], im[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] im, input logic [4:0] rd);
    return {im[20], im[10:1], im[11], im[19:12], rd, 7'h6f};
  endfunction

  // Reference result of an RV32I ALU operation, from funct3 and the funct7 bit 5.
  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
      input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, ((a[31] != b[31]) ? a[31] : (a < b))};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? ((a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0])))
                          : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic emit(input logic [31:0] w);
    rom[pw] = w;
    pw++;
  endtask

  task automatic store_out(input logic [4:0] rs, input logic [31:0] d);
    emit(enc_s(out_off[11:0], rs, 5'd3, 3'd2));
    exp_q.push_back('{addr: 32'h100 + out_off, data: d, be: 4'hf});
    out_off += 4;
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] up;
    up = (v + 32'h800) >> 12;
    emit({up[19:0], rd, 7'h37});
    emit(enc_i(v[11:0], rd, 3'd0, rd, 7'h13));
  endtask

  // A taken branch skips the poison store. A branch not taken runs a marker store
  // and then jumps over the poison store.
  task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
      input logic [4:0] rs2, input logic taken);
    if (taken) begin
      emit(enc_b(13'd8, rs2, rs1, f3));
    end else begin
      emit(enc_b(13'd12, rs2, rs1, f3));
      store_out(5'd9, 32'd1);
      emit(enc_j(21'd8, 5'd0));
    end
    emit(enc_s(12'h7f0, 5'd10, 5'd3, 3'd2));  // Poison store.
  endtask

  task automatic build_program();
    logic [31:0] ref_pc;
    pw      = 0;
    out_off = 0;
    va      = lfsr_bits(32);
    vb      = lfsr_bits(32);
    load_reg(5'd1, va);
    load_reg(5'd2, vb);
    emit(enc_i(12'h100, 5'd0, 3'd0, 5'd3, 7'h13));
    emit(enc_i(12'd1, 5'd0, 3'd0, 5'd9, 7'h13));
    emit(enc_i(12'hfff, 5'd0, 3'd0, 5'd10, 7'h13));
    // Register-register operations.
    for (int f = 0; f < 8; f++) begin
      emit(enc_r(7'h00, 5'd2, 5'd1, f[2:0], 5'd4));
      store_out(5'd4, alu_model(f[2:0], 1'b0, va, vb));
      if (f == 0 || f == 5) begin
        emit(enc_r(7'h20, 5'd2, 5'd1, f[2:0], 5'd4));
        store_out(5'd4, alu_model(f[2:0], 1'b1, va, vb));
      end
    end
    // Register-immediate operations.
    for (int f = 0; f < 8; f++) begin
      if (f == 1 || f == 5) begin
        imm = lfsr_bits(5);
        emit(enc_i({7'h00, imm[4:0]}, 5'd1, f[2:0], 5'd4, 7'h13));
        store_out(5'd4, alu_model(f[2:0], 1'b0, va, imm));
        if (f == 5) begin
          emit(enc_i({7'h20, imm[4:0]}, 5'd1, f[2:0], 5'd4, 7'h13));
          store_out(5'd4, alu_model(f[2:0], 1'b1, va, imm));
        end
      end else begin
        imm = lfsr_bits(12);
        emit(enc_i(imm[11:0], 5'd1, f[2:0], 5'd4, 7'h13));
        store_out(5'd4, alu_model(f[2:0], 1'b0, va, {{20{imm[11]}}, imm[11:0]}));
      end
    end
    // Narrow stores at every legal offset.
    for (int k = 0; k < 4; k++) begin
      emit(enc_s(12'h400 + k, 5'd2, 5'd3, 3'd0));
      exp_q.push_back('{addr: 32'h500 + k, data: {4{vb[7:0]}}, be: 4'b0001 << k});
    end
    for (int k = 0; k < 4; k += 2) begin
      emit(enc_s(12'h400 + k, 5'd2, 5'd3, 3'd1));
      exp_q.push_back('{addr: 32'h500 + k, data: {2{vb[15:0]}},
                        be: (k == 2) ? 4'b1100 : 4'b0011});
    end
    // Loads read back a stored word of x1.
    emit(enc_s(12'h500, 5'd1, 5'd3, 3'd2));
    exp_q.push_back('{addr: 32'h600, data: va, be: 4'hf});
    for (int k = 0; k < 4; k++) begin
      emit(enc_i(12'h500 + k, 5'd3, 3'd0, 5'd5, 7'h03));
      store_out(5'd5, {{24{va[8*k+7]}}, va[8*k +: 8]});
      emit(enc_i(12'h500 + k, 5'd3, 3'd4, 5'd5, 7'h03));
      store_out(5'd5, {24'd0, va[8*k +: 8]});
    end
    for (int k = 0; k < 4; k += 2) begin
      emit(enc_i(12'h500 + k, 5'd3, 3'd1, 5'd5, 7'h03));
      store_out(5'd5, {{16{va[8*k+15]}}, va[8*k +: 16]});
      emit(enc_i(12'h500 + k, 5'd3, 3'd5, 5'd5, 7'h03));
      store_out(5'd5, {16'd0, va[8*k +: 16]});
    end
    emit(enc_i(12'h500, 5'd3, 3'd2, 5'd5, 7'h03));
    store_out(5'd5, va);
    // Branches with x9 = 1 and x10 = -1.
    branch_case(3'd0, 5'd9, 5'd9, 1'b1);
    branch_case(3'd0, 5'd9, 5'd10, 1'b0);
    branch_case(3'd1, 5'd9, 5'd10, 1'b1);
    branch_case(3'd1, 5'd9, 5'd9, 1'b0);
    branch_case(3'd4, 5'd10, 5'd9, 1'b1);
    branch_case(3'd4, 5'd9, 5'd10, 1'b0);
    branch_case(3'd5, 5'd9, 5'd10, 1'b1);
    branch_case(3'd5, 5'd10, 5'd9, 1'b0);
    branch_case(3'd6, 5'd9, 5'd10, 1'b1);
    branch_case(3'd6, 5'd10, 5'd9, 1'b0);
    branch_case(3'd7, 5'd10, 5'd9, 1'b1);
    branch_case(3'd7, 5'd9, 5'd10, 1'b0);
    // Jumps store their link values.
    ref_pc = pw * 4;
    emit(enc_j(21'd8, 5'd12));
    emit(enc_s(12'h7f0, 5'd10, 5'd3, 3'd2));
    store_out(5'd12, ref_pc + 4);
    ref_pc = (pw + 1) * 4;
    emit(enc_i(ref_pc[11:0] + 12'd9, 5'd0, 3'd0, 5'd13, 7'h13));  // Odd target.
    emit(enc_i(12'd0, 5'd13, 3'd0, 5'd14, 7'h67));
    emit(enc_s(12'h7f0, 5'd10, 5'd3, 3'd2));
    store_out(5'd14, ref_pc + 4);
    // The illegal word must leave x31 at zero.
    store_out(5'd1, va);
    emit(enc_r(7'h7f, 5'd2, 5'd1, 3'd0, 5'd31));  // Would write x1 + x2 if executed.
    store_out(5'd31, 32'd0);
    end_pc = pw * 4;
    emit(enc_j(21'd0, 5'd0));
    limit = 2 * pw + 50;
  endtask

  // ************************************************
  // Data memory and store checker
  // ************************************************

  always @(posedge clk_i) begin
    if (data_req_o && !rst_n_i) begin
      if (data_we_o) begin
        for (int b = 0; b < 4; b++) begin
          if (data_be_o[b]) ram[data_addr_o[11:2]][8*b +: 8] = data_wdata_o[8*b +: 8];
        end
      end else begin
        data_rdata_i <= ram[data_addr_o[11:2]];
      end
    end
  end

  always @(posedge clk_i) begin
    if (!rst_n_i && data_req_o && data_we_o) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("unexpected store to %h at %0t", data_addr_o, $time);
      end else begin
        cur_store = exp_q.pop_front();
        assert (data_addr_o == cur_store.addr) else begin
          mismatches++;
          $display("mismatch at %0t: data_addr_o got %h expected %h",
                   $time, data_addr_o, cur_store.addr);
        end
        assert (data_wdata_o == cur_store.data) else begin
          mismatches++;
          $display("mismatch at %0t: data_wdata_o got %h expected %h",
                   $time, data_wdata_o, cur_store.data);
        end
        assert (data_be_o == cur_store.be) else begin
          mismatches++;
          $display("mismatch at %0t: data_be_o got %h expected %h",
                   $time, data_be_o, cur_store.be);
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles, program never reached its end", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    rst_n_i      <= 1'b1;  // Reset is active high.
    data_rdata_i <= '0;
    for (int i = 0; i < 256; i++) rom[i] = 32'h0000_0013;
    for (int i = 0; i < 1024; i++) ram[i] = {i[15:0] ^ 16'h5a5a, ~i[15:0]};
    build_program();
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b0;
    while (instr_addr_o != end_pc) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("%0d expected stores never appeared", exp_q.size());
    end
    $display("errors: mismatches %0d, other %0d, assertions %0d",
             mismatches, other_errors, uut.u_assert.fail_count);
    if (mismatches + other_errors + uut.u_assert.fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- miriscv_core.f
+incdir+include
src/miriscv_pkg.sv
src/miriscv_alu.sv
src/miriscv_decoder.sv
src/miriscv_regfile.sv
src/miriscv_lsu.sv
src/miriscv_core.sv
test/miriscv_core_assert.sv
test/miriscv_core_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = miriscv_core_tb
FILELIST = miriscv_core.f
OBJDIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf $(OBJDIR)
